// File: mem_write_if.sv
// ####################
// one write port per command engine
// we is a one-cycle strobe, done may share the last write cycle
// ####################
`timescale 1ns/1ps
`default_nettype none

interface mem_write_if
    import panel_ctrl_pkg::*;
();

    ram_addr_t addr;
    ram_data_t data;
    logic we;
    logic done;

    modport engine (output addr, output data, output we, output done);

    modport dispatch (input addr, input data, input we, input done);

endinterface

`default_nettype wire

// File: panel_blank_engine.sv
// ####################
// writes zero to every address, one per clock, from address 0
// first write one cycle after start, done with the last write
// ####################
`timescale 1ns/1ps
`default_nettype none

module panel_blank_engine
    import panel_ctrl_pkg::*;
(
    input wire logic clk_in,
    input wire logic reset,
    input wire logic start,
    mem_write_if.engine port
);

    logic running;
    ram_addr_t addr_q;
    logic last_addr;

    assign last_addr = running && (addr_q == ram_addr_t'(MEM_DEPTH - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            running <= 1'b0;
            addr_q <= '0;
        end else if (start) begin
            running <= 1'b1;
            addr_q <= '0;
        end else if (running) begin
            addr_q <= addr_q + 1'b1;
            if (last_addr) begin
                running <= 1'b0;
            end
        end
    end

    assign port.addr = addr_q;
    assign port.data = '0;
    assign port.we = running;
    assign port.done = last_addr;

endmodule

`default_nettype wire

// File: panel_cmd_dispatch.sv
// ####################
// a byte is decoded at the edge that accepts it, nothing is buffered
// ready_for_data stays low for the whole blank sweep
// ####################
`timescale 1ns/1ps
`default_nettype none

module panel_cmd_dispatch
    import panel_ctrl_pkg::*;
(
    input wire logic clk_in,
    input wire logic reset,
    input wire logic [7:0] data_rx,
    input wire logic data_ready_n,
    output logic [2:0] rgb_enable,
    output brightness_t brightness_enable,
    output logic busy,
    output logic ready_for_data,
    output ram_addr_t ram_address,
    output ram_data_t ram_data_out,
    output logic ram_write_enable,
    output logic [7:0] arg_byte,
    output logic pixel_arg_valid,
    output logic pixel_start,
    output logic blank_start,
    mem_write_if.dispatch pixel_port,
    mem_write_if.dispatch blank_port
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BRIGHT_ARG,
        ST_PIXEL,
        ST_BLANK
    } cmd_state_t;

    cmd_state_t state;
    opcode_t opcode;
    logic accept;
    logic pixel_last;
    logic decode_en;

    assign opcode = opcode_t'(data_rx);
    assign ready_for_data = (state != ST_BLANK);
    assign accept = ~data_ready_n && ready_for_data;

    // the last pixel write goes out while the byte path is already free
    assign pixel_last = (state == ST_PIXEL) && pixel_port.done;
    assign busy = (state != ST_IDLE) && !pixel_last;
    assign decode_en = accept && !busy;

    assign arg_byte = data_rx;
    assign pixel_arg_valid = accept && (state == ST_PIXEL) && !pixel_last;
    assign pixel_start = decode_en && (opcode == WRITE_PIXEL);
    assign blank_start = decode_en && (opcode == BLANK_PANEL);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= ST_IDLE;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            case (state)
                ST_BRIGHT_ARG: begin
                    if (accept) begin
                        brightness_enable <= data_rx[BRIGHTNESS_LEVELS-1:0];
                        state <= ST_IDLE;
                    end
                end
                ST_PIXEL: begin
                    if (pixel_last) begin
                        state <= ST_IDLE;
                    end
                end
                ST_BLANK: begin
                    if (blank_port.done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                end
            endcase

            // new opcode, may follow a pixel command's last argument directly
            if (decode_en) begin
                case (opcode)
                    RED_ON: rgb_enable[0] <= 1'b1;
                    RED_OFF: rgb_enable[0] <= 1'b0;
                    GREEN_ON: rgb_enable[1] <= 1'b1;
                    GREEN_OFF: rgb_enable[1] <= 1'b0;
                    BLUE_ON: rgb_enable[2] <= 1'b1;
                    BLUE_OFF: rgb_enable[2] <= 1'b0;
                    BRIGHT_ZERO: brightness_enable <= '0;
                    BRIGHT_ONE: brightness_enable[5] <= ~brightness_enable[5];
                    BRIGHT_TWO: brightness_enable[4] <= ~brightness_enable[4];
                    BRIGHT_THREE: brightness_enable[3] <= ~brightness_enable[3];
                    BRIGHT_FOUR: brightness_enable[2] <= ~brightness_enable[2];
                    BRIGHT_FIVE: brightness_enable[1] <= ~brightness_enable[1];
                    BRIGHT_SIX: brightness_enable[0] <= ~brightness_enable[0];
                    BRIGHT_ALL: brightness_enable <= '1;
                    SET_BRIGHTNESS: state <= ST_BRIGHT_ARG;
                    WRITE_PIXEL: state <= ST_PIXEL;
                    BLANK_PANEL: state <= ST_BLANK;
                    default: begin
                    end
                endcase
            end
        end
    end

    // memory port follows the active command
    always_comb begin
        ram_address = '0;
        ram_data_out = '0;
        ram_write_enable = 1'b0;
        case (state)
            ST_PIXEL: begin
                ram_address = pixel_port.addr;
                ram_data_out = pixel_port.data;
                ram_write_enable = pixel_port.we;
            end
            ST_BLANK: begin
                ram_address = blank_port.addr;
                ram_data_out = blank_port.data;
                ram_write_enable = blank_port.we;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: panel_ctrl_chk.sv
// ####################
// concurrent checks bound into panel_ctrl_top
// a write is legal only while busy or in the cycle after busy
// ####################
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_chk
    import panel_ctrl_pkg::*;
(
    input wire logic clk_in,
    input wire logic reset,
    input wire logic [2:0] rgb_enable,
    input wire brightness_t brightness_enable,
    input wire ram_data_t ram_data_out,
    input wire logic ram_write_enable,
    input wire logic busy,
    input wire logic ready_for_data
);

    reset_values: assert property (@(posedge clk_in)
        $past(reset) |-> rgb_enable == 3'b111 && brightness_enable == '1
            && !ram_write_enable && !busy && ready_for_data)
        else $error("outputs not at their reset values");

    not_ready_means_busy: assert property (@(posedge clk_in) disable iff (reset)
        !ready_for_data |-> busy)
        else $error("ready_for_data low while not busy");

    // last pixel write lands in the cycle where busy has just dropped
    no_idle_write: assert property (@(posedge clk_in) disable iff (reset)
        ram_write_enable |-> busy || $past(busy))
        else $error("memory write while idle");

    blank_writes_zero: assert property (@(posedge clk_in) disable iff (reset)
        ram_write_enable && !ready_for_data |-> ram_data_out == '0)
        else $error("blank sweep wrote nonzero data");

endmodule

bind panel_ctrl_top panel_ctrl_chk i_panel_ctrl_chk (
    .clk_in           (clk_in),
    .reset            (reset),
    .rgb_enable       (rgb_enable),
    .brightness_enable(brightness_enable),
    .ram_data_out     (ram_data_out),
    .ram_write_enable (ram_write_enable),
    .busy             (busy),
    .ready_for_data   (ready_for_data)
);

`default_nettype wire

// File: panel_ctrl_pkg.sv
// ####################
// panel geometry, opcodes and memory types for the command decoder
// address packs row high, then column, then pixel byte
// ####################
`default_nettype none

package panel_ctrl_pkg;

    localparam int unsigned ROW_BITS = 4;
    localparam int unsigned COL_BITS = 5;
    // two bytes per pixel
    localparam int unsigned PIXEL_BITS = 1;
    localparam int unsigned ADDR_BITS = ROW_BITS + COL_BITS + PIXEL_BITS;
    localparam int unsigned MEM_DEPTH = 2 ** ADDR_BITS;
    localparam int unsigned BRIGHTNESS_LEVELS = 6;

    typedef logic [ADDR_BITS-1:0] ram_addr_t;
    typedef logic [7:0] ram_data_t;
    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;

    typedef enum logic [7:0] {
        RED_ON         = 8'h10,
        RED_OFF        = 8'h11,
        GREEN_ON       = 8'h12,
        GREEN_OFF      = 8'h13,
        BLUE_ON        = 8'h14,
        BLUE_OFF       = 8'h15,
        BRIGHT_ZERO    = 8'h20,
        // BRIGHT_k toggles plane BRIGHTNESS_LEVELS-k
        BRIGHT_ONE     = 8'h21,
        BRIGHT_TWO     = 8'h22,
        BRIGHT_THREE   = 8'h23,
        BRIGHT_FOUR    = 8'h24,
        BRIGHT_FIVE    = 8'h25,
        BRIGHT_SIX     = 8'h26,
        BRIGHT_ALL     = 8'h29,
        SET_BRIGHTNESS = 8'h30,
        BLANK_PANEL    = 8'h40,
        WRITE_PIXEL    = 8'h50
    } opcode_t;

endpackage

`default_nettype wire

// File: panel_ctrl_tb.sv
// ####################
// a byte is held on data_rx until the DUT takes it
// outputs sampled on the falling edge, stops at the first error
// ####################
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_tb
    import panel_ctrl_pkg::*;
();

    localparam int unsigned CLK_PERIOD = 20;
    // blank sweep plus byte traffic, about twice over
    localparam int unsigned WATCHDOG_CYCLES = 2 * (MEM_DEPTH + 1500);

    logic clk_in;
    logic reset;
    logic [7:0] data_rx;
    logic data_ready_n;
    logic [2:0] rgb_enable;
    brightness_t brightness_enable;
    ram_addr_t ram_address;
    ram_data_t ram_data_out;
    logic ram_write_enable;
    logic busy;
    logic ready_for_data;

    logic [2:0] rgb_model;
    brightness_t bright_model;
    ram_addr_t exp_addr[$];
    ram_data_t exp_data[$];

    panel_ctrl_top i_panel_ctrl_top (.*);

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish in time");
        $display("Verification failed");
        $fatal(1);
    end

    task automatic report_failure(input string kind, input string msg);
        $display("%s at %0t: %s", kind, $time, msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // got/expected pairs
    task automatic expect_state(input logic busy_exp);
        @(negedge clk_in);
        assert (rgb_enable === rgb_model && brightness_enable === bright_model
                && busy === busy_exp)
        else report_failure("MISMATCH", $sformatf("rgb %b/%b brightness %b/%b busy %b/%b",
            rgb_enable, rgb_model, brightness_enable, bright_model, busy, busy_exp));
    endtask

    function automatic void apply_opcode(input logic [7:0] b);
        case (b)
            RED_ON: rgb_model[0] = 1'b1;
            RED_OFF: rgb_model[0] = 1'b0;
            GREEN_ON: rgb_model[1] = 1'b1;
            GREEN_OFF: rgb_model[1] = 1'b0;
            BLUE_ON: rgb_model[2] = 1'b1;
            BLUE_OFF: rgb_model[2] = 1'b0;
            BRIGHT_ZERO: bright_model = '0;
            BRIGHT_ALL: bright_model = '1;
            default: begin
                // BRIGHT_k toggles plane BRIGHTNESS_LEVELS-k
                if (b >= 8'h21 && b <= 8'h26) begin
                    bright_model[BRIGHTNESS_LEVELS - (b - 8'h20)] ^= 1'b1;
                end
            end
        endcase
    endfunction

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk_in);
        data_rx <= b;
        data_ready_n <= 1'b0;
        @(negedge clk_in);
        while (!ready_for_data) begin
            @(negedge clk_in);
        end
        // taken at this edge
        @(posedge clk_in);
        data_ready_n <= 1'b1;
    endtask

    task automatic single_opcode(input logic [7:0] b);
        apply_opcode(b);
        send_byte(b);
        expect_state(1'b0);
    endtask

    task automatic set_brightness(input logic [7:0] arg);
        send_byte(SET_BRIGHTNESS);
        expect_state(1'b1);
        send_byte(arg);
        bright_model = arg[BRIGHTNESS_LEVELS-1:0];
        expect_state(1'b0);
    endtask

    task automatic write_pixel(
        input logic [7:0] row,
        input logic [7:0] col,
        input logic [7:0] d0,
        input logic [7:0] d1
    );
        exp_addr.push_back({row[ROW_BITS-1:0], col[COL_BITS-1:0], 1'b0});
        exp_data.push_back(d0);
        exp_addr.push_back({row[ROW_BITS-1:0], col[COL_BITS-1:0], 1'b1});
        exp_data.push_back(d1);
        send_byte(WRITE_PIXEL);
        expect_state(1'b1);
        send_byte(row);
        expect_state(1'b1);
        send_byte(col);
        expect_state(1'b1);
        send_byte(d0);
        expect_state(1'b1);
        send_byte(d1);
        expect_state(1'b0);
        @(posedge clk_in);
        assert (exp_addr.size() == 0)
        else report_failure("ERROR", "pixel writes did not all appear");
    endtask

    task automatic blank_panel();
        int i;
        for (i = 0; i < MEM_DEPTH; i++) begin
            exp_addr.push_back(ram_addr_t'(i));
            exp_data.push_back('0);
        end
        send_byte(BLANK_PANEL);
        for (i = 0; i < MEM_DEPTH; i++) begin
            @(negedge clk_in);
            assert (ram_write_enable && busy && !ready_for_data)
            else report_failure("MISMATCH", $sformatf("blank sweep broke at write %0d", i));
            @(posedge clk_in);
            // offered mid-sweep and dropped before ready returns
            if (i == 4) begin
                data_rx <= (bright_model == '0) ? BRIGHT_ALL : BRIGHT_ZERO;
                data_ready_n <= 1'b0;
            end else if (i == 20) begin
                data_ready_n <= 1'b1;
            end
        end
        expect_state(1'b0);
        assert (ready_for_data && !ram_write_enable)
        else report_failure("MISMATCH", "blank sweep did not end cleanly");
    endtask

    always @(negedge clk_in) begin
        if (!reset && ram_write_enable) begin
            if (exp_addr.size() == 0) begin
                report_failure("ERROR", "memory write with none pending");
            end else begin
                assert (ram_address === exp_addr[0] && ram_data_out === exp_data[0])
                else report_failure("MISMATCH", $sformatf("write %h:%h, expected %h:%h",
                    ram_address, ram_data_out, exp_addr[0], exp_data[0]));
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        int i;
        logic [7:0] b;
        void'($urandom(32'h6040a1c1));
        reset = 1'b1;
        data_rx = 8'h00;
        data_ready_n = 1'b1;
        rgb_model = 3'b111;
        bright_model = '1;
        repeat (2) @(posedge clk_in);
        reset <= 1'b0;
        expect_state(1'b0);
        assert (!ram_write_enable && ready_for_data)
        else report_failure("MISMATCH", "write enable or ready wrong after reset");

        // channels off in turn, then on, then random
        for (i = 0; i < 6; i++) begin
            single_opcode(8'h11 + 2 * (i % 3) - (i / 3));
        end
        for (i = 0; i < 20; i++) begin
            single_opcode(8'h10 + $urandom % 6);
        end
        for (i = 0; i < 20; i++) begin
            b = $urandom;
            while (b inside {[8'h10:8'h15], [8'h20:8'h26], 8'h29, 8'h30, 8'h40, 8'h50}) begin
                b = $urandom;
            end
            single_opcode(b);
        end

        // each plane off then back on
        for (i = 0; i < 12; i++) begin
            single_opcode(8'h21 + i % 6);
        end
        single_opcode(BRIGHT_ZERO);
        for (i = 0; i < 6; i++) begin
            single_opcode(8'h21 + i);
        end
        single_opcode(BRIGHT_ZERO);
        single_opcode(BRIGHT_ALL);
        for (i = 0; i < 4; i++) begin
            set_brightness($urandom);
        end

        for (i = 0; i < 4; i++) begin
            write_pixel($urandom, $urandom, $urandom, $urandom);
        end
        blank_panel();
        write_pixel($urandom, $urandom, $urandom, $urandom);

        @(posedge clk_in);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: panel_ctrl_top.f
panel_ctrl_pkg.sv
mem_write_if.sv
pixel_write_engine.sv
panel_blank_engine.sv
panel_cmd_dispatch.sv
panel_ctrl_top.sv
panel_ctrl_chk.sv
panel_ctrl_tb.sv

// File: panel_ctrl_top.sv
// ####################
// byte-wide command decoder for the panel frame memory
// data_ready_n low offers a byte, taken only while ready_for_data
// ####################
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top
    import panel_ctrl_pkg::*;
(
    input wire logic clk_in,
    input wire logic reset,
    input wire logic [7:0] data_rx,
    input wire logic data_ready_n,
    output logic [2:0] rgb_enable,
    output brightness_t brightness_enable,
    output ram_addr_t ram_address,
    output ram_data_t ram_data_out,
    output logic ram_write_enable,
    output logic busy,
    output logic ready_for_data
);

    logic [7:0] arg_byte;
    logic pixel_arg_valid;
    logic pixel_start;
    logic blank_start;

    mem_write_if pixel_if ();
    mem_write_if blank_if ();

    panel_cmd_dispatch i_panel_cmd_dispatch (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .data_ready_n     (data_ready_n),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .busy             (busy),
        .ready_for_data   (ready_for_data),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable),
        .arg_byte         (arg_byte),
        .pixel_arg_valid  (pixel_arg_valid),
        .pixel_start      (pixel_start),
        .blank_start      (blank_start),
        .pixel_port       (pixel_if.dispatch),
        .blank_port       (blank_if.dispatch)
    );

    pixel_write_engine i_pixel_write_engine (
        .clk_in   (clk_in),
        .reset    (reset),
        .start    (pixel_start),
        .arg_byte (arg_byte),
        .arg_valid(pixel_arg_valid),
        .port     (pixel_if.engine)
    );

    panel_blank_engine i_panel_blank_engine (
        .clk_in(clk_in),
        .reset (reset),
        .start (blank_start),
        .port  (blank_if.engine)
    );

endmodule

`default_nettype wire

// File: pixel_write_engine.sv
// ####################
// argument order is row, column, data byte 0, data byte 1
// each data byte gives one registered write a cycle after its strobe
// ####################
`timescale 1ns/1ps
`default_nettype none

module pixel_write_engine
    import panel_ctrl_pkg::*;
(
    input wire logic clk_in,
    input wire logic reset,
    input wire logic start,
    input wire logic [7:0] arg_byte,
    input wire logic arg_valid,
    mem_write_if.engine port
);

    // 0 row, 1 column, 2 data byte 0, 3 data byte 1
    logic [1:0] arg_count;
    logic [ROW_BITS-1:0] row_q;
    logic [COL_BITS-1:0] col_q;
    ram_addr_t addr_q;
    ram_data_t data_q;
    logic we_q;
    logic done_q;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_count <= 2'd0;
            we_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            we_q <= 1'b0;
            done_q <= 1'b0;
            if (start) begin
                arg_count <= 2'd0;
            end else if (arg_valid) begin
                // wraps back to the row slot after data byte 1
                arg_count <= arg_count + 2'd1;
                case (arg_count)
                    2'd0: row_q <= arg_byte[ROW_BITS-1:0];
                    2'd1: col_q <= arg_byte[COL_BITS-1:0];
                    default: begin
                        // low counter bit picks the byte within the pixel
                        addr_q <= {row_q, col_q, arg_count[PIXEL_BITS-1:0]};
                        data_q <= arg_byte;
                        we_q <= 1'b1;
                        done_q <= (arg_count == 2'd3);
                    end
                endcase
            end
        end
    end

    assign port.addr = addr_q;
    assign port.data = data_q;
    assign port.we = we_q;
    assign port.done = done_q;

endmodule

`default_nettype wire
